// ==== logic/mci_macros.svh ====
`ifndef MCI_MACROS_SVH
`define MCI_MACROS_SVH

// Bus and vector widths
`define MCI_ADDR_W 12
`define MCI_DATA_W 32
`define MCI_ERR_W  32

// Watchdog timer 1
`define MCI_REG_T1_EN     12'h000
`define MCI_REG_T1_CTRL   12'h004
`define MCI_REG_T1_PERIOD 12'h008

// Watchdog timer 2
`define MCI_REG_T2_EN     12'h00C
`define MCI_REG_T2_CTRL   12'h010
`define MCI_REG_T2_PERIOD 12'h014

// Interrupt and error control
`define MCI_REG_INTR_STS       12'h018
`define MCI_REG_INTR_EN        12'h01C
`define MCI_REG_ERR_FATAL_MASK 12'h020
`define MCI_REG_ERR_NF_MASK    12'h024
`define MCI_REG_ERR_FATAL_STS  12'h028
`define MCI_REG_ERR_NF_STS     12'h02C

`endif

// ==== logic/mci_pkg.sv ====
`default_nettype none

package mci_pkg;

    `include "mci_macros.svh"

    typedef logic [`MCI_ADDR_W-1:0]   mci_addr_t;
    typedef logic [`MCI_DATA_W-1:0]   mci_data_t;
    typedef logic [`MCI_DATA_W/8-1:0] mci_strb_t;
    typedef logic [`MCI_DATA_W-1:0]   wdt_period_t;
    typedef logic [`MCI_ERR_W-1:0]    err_vec_t;

    // AXI4-Lite response codes
    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

    // Manager to subordinate
    typedef struct packed {
        mci_addr_t awaddr;
        logic      awvalid;
        mci_data_t wdata;
        mci_strb_t wstrb;
        logic      wvalid;
        logic      bready;
        mci_addr_t araddr;
        logic      arvalid;
        logic      rready;
    } axil_req_t;

    // Subordinate to manager
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        mci_data_t  rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic        en;
        logic        restart;
        wdt_period_t period;
    } wdt_cfg_t;

    // The clr fields are one-cycle strobes with the written data
    typedef struct packed {
        logic [1:0] intr_en;
        err_vec_t   fatal_mask;
        err_vec_t   nf_mask;
        logic [1:0] intr_clr;
        err_vec_t   fatal_clr;
        err_vec_t   nf_clr;
    } intr_cfg_t;

    typedef struct packed {
        logic [1:0] intr_sts;
        err_vec_t   fatal_sts;
        err_vec_t   nf_sts;
    } intr_sts_t;

    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } wr_state_e;

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_e;

endpackage

`default_nettype wire

// ==== logic/mci_csr_axil.sv ====
`default_nettype none

`include "mci_macros.svh"

module mci_csr_axil
    import mci_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  axil_req_t axil_req_i,
    output axil_rsp_t axil_rsp_o,
    input  intr_sts_t sts_i,
    output wdt_cfg_t  t1_cfg_o,
    output wdt_cfg_t  t2_cfg_o,
    output intr_cfg_t intr_cfg_o
);

    wr_state_e  wr_state_q;
    rd_state_e  rd_state_q;
    logic       wr_hs;
    logic       rd_hs;
    logic [1:0] bresp_q;
    mci_data_t  rdata_q;
    logic [1:0] rresp_q;
    mci_data_t  rd_data_d;
    logic       rd_err_d;
    wdt_cfg_t   t1_cfg_q;
    wdt_cfg_t   t2_cfg_q;
    intr_cfg_t  intr_cfg_q;

    // Write needs address and data together
    assign wr_hs = (wr_state_q == WR_IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
    assign rd_hs = (rd_state_q == RD_IDLE) && axil_req_i.arvalid;

    always_comb begin
        axil_rsp_o.awready = wr_hs;
        axil_rsp_o.wready  = wr_hs;
        axil_rsp_o.bvalid  = (wr_state_q == WR_RESP);
        axil_rsp_o.bresp   = bresp_q;
        axil_rsp_o.arready = rd_hs;
        axil_rsp_o.rvalid  = (rd_state_q == RD_DATA);
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = rresp_q;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_state_q <= WR_IDLE;
        end else begin
            case (wr_state_q)
                WR_IDLE: if (wr_hs) wr_state_q <= WR_RESP;
                WR_RESP: if (axil_req_i.bready) wr_state_q <= WR_IDLE;
                default: wr_state_q <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_state_q <= RD_IDLE;
        end else begin
            case (rd_state_q)
                RD_IDLE: if (rd_hs) rd_state_q <= RD_DATA;
                RD_DATA: if (axil_req_i.rready) rd_state_q <= RD_IDLE;
                default: rd_state_q <= RD_IDLE;
            endcase
        end
    end

    // Register writes and strobes
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            t1_cfg_q   <= '0;
            t2_cfg_q   <= '0;
            intr_cfg_q <= '0;
            bresp_q    <= AXI_RESP_OKAY;
        end else begin
            t1_cfg_q.restart     <= 1'b0;
            t2_cfg_q.restart     <= 1'b0;
            intr_cfg_q.intr_clr  <= '0;
            intr_cfg_q.fatal_clr <= '0;
            intr_cfg_q.nf_clr    <= '0;
            if (wr_hs) begin
                bresp_q <= AXI_RESP_OKAY;
                // Partial strobes are rejected without side effects
                if (axil_req_i.wstrb != '1) begin
                    bresp_q <= AXI_RESP_SLVERR;
                end else begin
                    case (axil_req_i.awaddr)
                        `MCI_REG_T1_EN:          t1_cfg_q.en <= axil_req_i.wdata[0];
                        `MCI_REG_T1_CTRL:        t1_cfg_q.restart <= axil_req_i.wdata[0];
                        `MCI_REG_T1_PERIOD:      t1_cfg_q.period <= axil_req_i.wdata;
                        `MCI_REG_T2_EN:          t2_cfg_q.en <= axil_req_i.wdata[0];
                        `MCI_REG_T2_CTRL:        t2_cfg_q.restart <= axil_req_i.wdata[0];
                        `MCI_REG_T2_PERIOD:      t2_cfg_q.period <= axil_req_i.wdata;
                        `MCI_REG_INTR_STS:       intr_cfg_q.intr_clr <= axil_req_i.wdata[1:0];
                        `MCI_REG_INTR_EN:        intr_cfg_q.intr_en <= axil_req_i.wdata[1:0];
                        `MCI_REG_ERR_FATAL_MASK: intr_cfg_q.fatal_mask <= axil_req_i.wdata;
                        `MCI_REG_ERR_NF_MASK:    intr_cfg_q.nf_mask <= axil_req_i.wdata;
                        `MCI_REG_ERR_FATAL_STS:  intr_cfg_q.fatal_clr <= axil_req_i.wdata;
                        `MCI_REG_ERR_NF_STS:     intr_cfg_q.nf_clr <= axil_req_i.wdata;
                        default:                 bresp_q <= AXI_RESP_SLVERR;
                    endcase
                end
            end
        end
    end

    // Read mux, unmapped addresses return zero
    always_comb begin
        rd_data_d = '0;
        rd_err_d  = 1'b0;
        case (axil_req_i.araddr)
            `MCI_REG_T1_EN:          rd_data_d[0] = t1_cfg_q.en;
            `MCI_REG_T1_PERIOD:      rd_data_d = t1_cfg_q.period;
            `MCI_REG_T2_EN:          rd_data_d[0] = t2_cfg_q.en;
            `MCI_REG_T2_PERIOD:      rd_data_d = t2_cfg_q.period;
            `MCI_REG_T1_CTRL,
            `MCI_REG_T2_CTRL:        rd_data_d = '0;
            `MCI_REG_INTR_STS:       rd_data_d[1:0] = sts_i.intr_sts;
            `MCI_REG_INTR_EN:        rd_data_d[1:0] = intr_cfg_q.intr_en;
            `MCI_REG_ERR_FATAL_MASK: rd_data_d = intr_cfg_q.fatal_mask;
            `MCI_REG_ERR_NF_MASK:    rd_data_d = intr_cfg_q.nf_mask;
            `MCI_REG_ERR_FATAL_STS:  rd_data_d = sts_i.fatal_sts;
            `MCI_REG_ERR_NF_STS:     rd_data_d = sts_i.nf_sts;
            default:                 rd_err_d = 1'b1;
        endcase
    end

    // Captured once per read, held until rready
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_q <= '0;
            rresp_q <= AXI_RESP_OKAY;
        end else if (rd_hs) begin
            rdata_q <= rd_data_d;
            rresp_q <= rd_err_d ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        end
    end

    assign t1_cfg_o   = t1_cfg_q;
    assign t2_cfg_o   = t2_cfg_q;
    assign intr_cfg_o = intr_cfg_q;

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid);

    a_rdata_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        axil_rsp_o.rvalid && !axil_req_i.rready |=> axil_rsp_o.rvalid && $stable(axil_rsp_o.rdata));

endmodule

`default_nettype wire

// ==== logic/mci_wdt_timer.sv ====
`default_nettype none

module mci_wdt_timer
    import mci_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  wdt_cfg_t cfg_i,
    output logic     timeout_p_o
);

    wdt_period_t count_q;
    logic        hit;

    // Period of zero disables the timeout
    assign hit = cfg_i.en && !cfg_i.restart && (cfg_i.period != '0) &&
                 (count_q == cfg_i.period);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (!cfg_i.en || cfg_i.restart) begin
            count_q <= '0;
        end else if (hit) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    // Single cycle pulse while the counter sits on the period
    assign timeout_p_o = hit;

    a_no_pulse_disabled: assert property (@(posedge clk) disable iff (!rst_n_i)
        !cfg_i.en |=> !timeout_p_o);

endmodule

`default_nettype wire

// ==== logic/mci_intr_combiner.sv ====
`default_nettype none

module mci_intr_combiner
    import mci_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      t1_timeout_p_i,
    input  logic      t2_timeout_p_i,
    input  err_vec_t  agg_error_fatal_i,
    input  err_vec_t  agg_error_non_fatal_i,
    input  intr_cfg_t cfg_i,
    output intr_sts_t sts_o,
    output logic      mci_intr_o,
    output logic      nmi_intr_o,
    output logic      all_error_fatal_o,
    output logic      all_error_non_fatal_o
);

    intr_sts_t sts_q;
    logic [1:0] timeout_set;

    assign timeout_set = {t2_timeout_p_i, t1_timeout_p_i};

    // Sticky status, a new event wins over a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sts_q <= '0;
        end else begin
            sts_q.intr_sts  <= (sts_q.intr_sts & ~cfg_i.intr_clr) | timeout_set;
            sts_q.fatal_sts <= (sts_q.fatal_sts & ~cfg_i.fatal_clr) | agg_error_fatal_i;
            sts_q.nf_sts    <= (sts_q.nf_sts & ~cfg_i.nf_clr) | agg_error_non_fatal_i;
        end
    end

    assign sts_o = sts_q;

    // Timer 2 timeout is non-maskable
    assign nmi_intr_o = sts_q.intr_sts[1];
    assign mci_intr_o = |(sts_q.intr_sts & cfg_i.intr_en);

    // Mask bit set means the line is ignored
    assign all_error_fatal_o     = |(sts_q.fatal_sts & ~cfg_i.fatal_mask);
    assign all_error_non_fatal_o = |(sts_q.nf_sts & ~cfg_i.nf_mask);

    a_nmi_fall_on_clear: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(nmi_intr_o) |-> $past(cfg_i.intr_clr[1]));

endmodule

`default_nettype wire

// ==== logic/mci_top.sv ====
`default_nettype none

module mci_top
    import mci_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,

    // AXI4-Lite control port
    input  axil_req_t axil_req_i,
    output axil_rsp_t axil_rsp_o,

    // SoC error lines
    input  err_vec_t  agg_error_fatal_i,
    input  err_vec_t  agg_error_non_fatal_i,

    // Interrupts and aggregated errors
    output logic      mci_intr_o,
    output logic      nmi_intr_o,
    output logic      all_error_fatal_o,
    output logic      all_error_non_fatal_o
);

    wdt_cfg_t  t1_cfg;
    wdt_cfg_t  t2_cfg;
    intr_cfg_t intr_cfg;
    intr_sts_t intr_sts;
    logic      t1_timeout_p;
    logic      t2_timeout_p;

    mci_csr_axil u_csr (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .axil_req_i (axil_req_i),
        .axil_rsp_o (axil_rsp_o),
        .sts_i      (intr_sts),
        .t1_cfg_o   (t1_cfg),
        .t2_cfg_o   (t2_cfg),
        .intr_cfg_o (intr_cfg)
    );

    // Two independent watchdogs
    mci_wdt_timer u_wdt1 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cfg_i       (t1_cfg),
        .timeout_p_o (t1_timeout_p)
    );

    mci_wdt_timer u_wdt2 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cfg_i       (t2_cfg),
        .timeout_p_o (t2_timeout_p)
    );

    mci_intr_combiner u_intr (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .t1_timeout_p_i        (t1_timeout_p),
        .t2_timeout_p_i        (t2_timeout_p),
        .agg_error_fatal_i     (agg_error_fatal_i),
        .agg_error_non_fatal_i (agg_error_non_fatal_i),
        .cfg_i                 (intr_cfg),
        .sts_o                 (intr_sts),
        .mci_intr_o            (mci_intr_o),
        .nmi_intr_o            (nmi_intr_o),
        .all_error_fatal_o     (all_error_fatal_o),
        .all_error_non_fatal_o (all_error_non_fatal_o)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_mci_top.sv ====
`default_nettype none

`include "mci_macros.svh"

module tb_mci_top
    import mci_pkg::*;
();

    localparam logic [31:0] SEED       = 32'h6d50_5c52;
    localparam int          TXN_MAX    = 160;
    localparam int          TXN_CYCLES = 8;

    // Read/write registers and their implemented bits
    localparam mci_addr_t RW_ADDR [7] = '{`MCI_REG_T1_EN, `MCI_REG_T1_PERIOD, `MCI_REG_T2_EN,
        `MCI_REG_T2_PERIOD, `MCI_REG_INTR_EN, `MCI_REG_ERR_FATAL_MASK, `MCI_REG_ERR_NF_MASK};
    localparam mci_data_t RW_MASK [7] = '{32'h1, 32'hffff_ffff, 32'h1, 32'hffff_ffff, 32'h3,
        32'hffff_ffff, 32'hffff_ffff};

    logic        clk;
    logic        rst_n_i;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    err_vec_t    agg_fatal;
    err_vec_t    agg_nf;
    logic        mci_intr;
    logic        nmi_intr;
    logic        err_fatal;
    logic        err_nf;
    logic [31:0] rng_state;
    logic [31:0] p1;
    logic [31:0] p2;
    logic [31:0] limit_cycles;
    logic        restart_phase;
    logic        nmi_hold;
    int          err_count;
    int          check_count;

    mci_top u_dut (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .axil_req_i            (axil_req),
        .axil_rsp_o            (axil_rsp),
        .agg_error_fatal_i     (agg_fatal),
        .agg_error_non_fatal_i (agg_nf),
        .mci_intr_o            (mci_intr),
        .nmi_intr_o            (nmi_intr),
        .all_error_fatal_o     (err_fatal),
        .all_error_non_fatal_o (err_nf)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            err_count++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        assert (got === exp) else begin
            err_count++;
            $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic axil_write(input mci_addr_t addr, input mci_data_t data,
                              input mci_strb_t strb, output logic [1:0] resp,
                              input int stall = 0);
        @(negedge clk);
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = (stall == 0);
        #1;
        while (!axil_rsp.awready) begin
            @(negedge clk);
            #1;
        end
        // Request stays valid while B is stalled
        repeat (stall + 1) @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        axil_req.bready  = 1'b1;
        while (!axil_rsp.bvalid) @(negedge clk);
        resp = axil_rsp.bresp;
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input mci_addr_t addr, output mci_data_t data,
                             output logic [1:0] resp, input int stall = 0);
        @(negedge clk);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = (stall == 0);
        #1;
        while (!axil_rsp.arready) begin
            @(negedge clk);
            #1;
        end
        repeat (stall + 1) @(negedge clk);
        axil_req.arvalid = 1'b0;
        axil_req.rready  = 1'b1;
        while (!axil_rsp.rvalid) @(negedge clk);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    // Full-strobe write that must be accepted
    task automatic write_reg(input mci_addr_t addr, input mci_data_t data);
        logic [1:0] resp;
        axil_write(addr, data, 4'hf, resp);
        check_value($sformatf("bresp@%h", addr), {30'd0, resp}, {30'd0, AXI_RESP_OKAY});
    endtask

    task automatic expect_reg(input mci_addr_t addr, input mci_data_t exp);
        mci_data_t  data;
        logic [1:0] resp;
        axil_read(addr, data, resp);
        check_value($sformatf("rresp@%h", addr), {30'd0, resp}, {30'd0, AXI_RESP_OKAY});
        check_value($sformatf("rdata@%h", addr), data, exp);
    endtask

    a_reset_idle: assert property (@(posedge clk) !rst_n_i |-> !axil_rsp.bvalid &&
        !axil_rsp.rvalid && !mci_intr && !nmi_intr && !err_fatal && !err_nf)
        else begin
            err_count++;
            $display("Fail at %0t: a response or output is active during reset", $time);
        end

    a_aw_w_together: assert property (@(posedge clk) axil_rsp.awready == axil_rsp.wready)
        else begin
            err_count++;
            $display("Fail at %0t: awready and wready differ", $time);
        end

    // No new transfer while a response waits
    a_busy_no_accept: assert property (@(posedge clk)
        !(axil_rsp.bvalid && axil_rsp.awready) && !(axil_rsp.rvalid && axil_rsp.arready))
        else begin
            err_count++;
            $display("Fail at %0t: a transfer was accepted during a pending response", $time);
        end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else begin
            err_count++;
            $display("Fail at %0t: bvalid dropped before bready", $time);
        end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else begin
            err_count++;
            $display("Fail at %0t: rvalid dropped or rdata changed before rready", $time);
        end

    a_restart_quiet: assert property (@(posedge clk) restart_phase |-> !mci_intr)
        else begin
            err_count++;
            $display("Fail at %0t: timer 1 fired although it was restarted in time", $time);
        end

    a_nmi_hold: assert property (@(posedge clk) nmi_hold |-> nmi_intr)
        else begin
            err_count++;
            $display("Fail at %0t: nmi_intr_o fell without a clear", $time);
        end

    initial begin : watchdog
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", limit_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main
        mci_data_t  wr_val [7];
        mci_data_t  rdata;
        logic [1:0] resp;
        logic [1:0] ie;
        err_vec_t   fv;
        err_vec_t   nv;
        err_vec_t   fm;
        err_vec_t   nm;
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        axil_req      = '0;
        agg_fatal     = '0;
        agg_nf        = '0;
        restart_phase = 1'b0;
        nmi_hold      = 1'b0;
        err_count     = 0;
        check_count   = 0;
        rng_state     = SEED;
        // Even periods between 16 and 78
        p1 = 32'd16 + ((next_random() >> 27) << 1);
        p2 = 32'd16 + ((next_random() >> 27) << 1);
        limit_cycles = 6 * p1 + p2 + 32'd64 + TXN_MAX * TXN_CYCLES;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        // Register readback, CTRL, unmapped and partial strobe
        for (int i = 0; i < 7; i++) begin
            wr_val[i] = next_random();
            write_reg(RW_ADDR[i], wr_val[i]);
        end
        for (int i = 0; i < 7; i++) begin
            expect_reg(RW_ADDR[i], wr_val[i] & RW_MASK[i]);
        end
        expect_reg(`MCI_REG_T1_CTRL, 32'd0);
        expect_reg(`MCI_REG_T2_CTRL, 32'd0);
        axil_read(12'h100, rdata, resp);
        check_value("rresp@100", {30'd0, resp}, {30'd0, AXI_RESP_SLVERR});
        check_value("rdata@100", rdata, 32'd0);
        axil_write(`MCI_REG_T1_PERIOD, next_random(), 4'b0111, resp);
        check_value("bresp partial", {30'd0, resp}, {30'd0, AXI_RESP_SLVERR});
        expect_reg(`MCI_REG_T1_PERIOD, wr_val[1]);

        // Back-pressure on B and R with the request still valid
        axil_write(`MCI_REG_ERR_FATAL_MASK, wr_val[5], 4'hf, resp, 3);
        check_value("bresp stalled", {30'd0, resp}, {30'd0, AXI_RESP_OKAY});
        axil_read(`MCI_REG_T1_PERIOD, rdata, resp, 3);
        check_value("rdata stalled", rdata, wr_val[1]);
        write_reg(`MCI_REG_T1_EN, 32'd0);
        write_reg(`MCI_REG_T2_EN, 32'd0);
        write_reg(`MCI_REG_INTR_STS, 32'd3);

        // Timer 1 timeout, with and without its interrupt enable
        write_reg(`MCI_REG_T1_PERIOD, p1);
        for (int k = 0; k < 2; k++) begin
            ie = (k == 0) ? 2'b01 : 2'b00;
            write_reg(`MCI_REG_INTR_EN, {30'd0, ie});
            write_reg(`MCI_REG_T1_EN, 32'd1);
            repeat (p1 + 4) @(negedge clk);
            expect_reg(`MCI_REG_INTR_STS, 32'd1);
            check_bit("mci_intr_o", mci_intr, ie[0]);
            write_reg(`MCI_REG_T1_EN, 32'd0);
            write_reg(`MCI_REG_INTR_STS, 32'd1);
            expect_reg(`MCI_REG_INTR_STS, 32'd0);
            check_bit("mci_intr_o", mci_intr, 1'b0);
        end

        // Restarts every P/2 keep timer 1 quiet
        write_reg(`MCI_REG_INTR_EN, 32'd1);
        write_reg(`MCI_REG_T1_EN, 32'd1);
        restart_phase = 1'b1;
        for (int n = 0; n < 8; n++) begin
            write_reg(`MCI_REG_T1_CTRL, 32'd1);
            repeat (p1 / 2 - 4) @(negedge clk);
        end
        expect_reg(`MCI_REG_INTR_STS, 32'd0);
        restart_phase = 1'b0;
        write_reg(`MCI_REG_T1_EN, 32'd0);

        // Timer 2 raises nmi regardless of intr_en
        ie = 2'(next_random() >> 30);
        write_reg(`MCI_REG_INTR_EN, {30'd0, ie});
        write_reg(`MCI_REG_T2_PERIOD, p2);
        write_reg(`MCI_REG_T2_EN, 32'd1);
        repeat (p2 + 4) @(negedge clk);
        check_bit("nmi_intr_o", nmi_intr, 1'b1);
        nmi_hold = 1'b1;
        write_reg(`MCI_REG_T2_EN, 32'd0);
        expect_reg(`MCI_REG_INTR_STS, 32'd2);
        check_bit("mci_intr_o", mci_intr, ie[1]);
        repeat (10) @(negedge clk);
        nmi_hold = 1'b0;
        write_reg(`MCI_REG_INTR_STS, 32'd2);
        @(negedge clk);
        check_bit("nmi_intr_o", nmi_intr, 1'b0);

        // Error aggregation against random masks
        for (int n = 0; n < 8; n++) begin
            fv = next_random();
            nv = next_random();
            fm = next_random();
            nm = next_random();
            write_reg(`MCI_REG_ERR_FATAL_MASK, fm);
            write_reg(`MCI_REG_ERR_NF_MASK, nm);
            @(negedge clk);
            agg_fatal = fv;
            agg_nf    = nv;
            @(negedge clk);
            agg_fatal = '0;
            agg_nf    = '0;
            expect_reg(`MCI_REG_ERR_FATAL_STS, fv);
            expect_reg(`MCI_REG_ERR_NF_STS, nv);
            check_bit("all_error_fatal_o", err_fatal, |(fv & ~fm));
            check_bit("all_error_non_fatal_o", err_nf, |(nv & ~nm));
            write_reg(`MCI_REG_ERR_FATAL_STS, 32'hffff_ffff);
            write_reg(`MCI_REG_ERR_NF_STS, 32'hffff_ffff);
            @(negedge clk);
            check_bit("all_error_fatal_o", err_fatal, 1'b0);
            check_bit("all_error_non_fatal_o", err_nf, 1'b0);
        end

        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/mci_pkg.sv
logic/mci_csr_axil.sv
logic/mci_wdt_timer.sv
logic/mci_intr_combiner.sv
logic/mci_top.sv
testbench/tb_mci_top.sv

// ==== Makefile ====
TOP := tb_mci_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
